/* design/maze_pkg.sv */
package maze_pkg;

    typedef logic [9:0] coord_t;

    localparam int     SPRITE_SIZE = 16;
    localparam coord_t STEP        = 10;
    localparam coord_t START_X     = 16;
    localparam coord_t START_Y     = 72;

    // Offsets from the near corner
    localparam coord_t FAR_OFS = coord_t'(SPRITE_SIZE - 1);
    localparam coord_t MID_OFS = coord_t'((SPRITE_SIZE - 1) / 2);

    typedef struct packed {
        coord_t x_lo;
        coord_t x_hi;
        coord_t y_lo;
        coord_t y_hi;
    } wall_t;

    // 31 horizontal and 33 vertical segments
    localparam int WALL_COUNT = 64;

    localparam wall_t WALLS [WALL_COUNT] = '{
        //////////////////////////////
        // Horizontal segments
        '{ 16, 463,  16,  23},
        '{ 16, 143,  56,  63},
        '{256, 383,  56,  63},
        '{ 16, 103,  96, 103},
        '{176, 303,  96, 103},
        '{336, 383,  96, 103},
        '{ 56, 103, 136, 143},
        '{136, 263, 136, 143},
        '{296, 343, 136, 143},
        '{376, 423, 136, 143},
        '{ 56, 103, 176, 183},
        '{216, 303, 176, 183},
        '{416, 463, 176, 183},
        '{ 96, 183, 216, 223},
        '{336, 383, 216, 223},
        '{ 16,  63, 256, 263},
        '{136, 223, 256, 263},
        '{296, 343, 256, 263},
        '{376, 423, 256, 263},
        '{136, 183, 296, 303},
        '{216, 263, 296, 303},
        '{336, 463, 296, 303},
        '{ 96, 143, 336, 343},
        '{256, 343, 336, 343},
        '{376, 423, 336, 343},
        '{ 96, 183, 376, 383},
        '{336, 463, 376, 383},
        '{136, 223, 416, 423},
        '{256, 303, 416, 423},
        '{376, 463, 416, 423},
        '{ 16, 463, 456, 463},
        //////////////////////////////
        // Vertical segments
        '{ 16,  23,  16,  63},
        '{ 16,  23,  96, 463},
        '{ 56,  63, 176, 263},
        '{ 56,  63, 296, 463},
        '{ 96, 103, 136, 183},
        '{ 96, 103, 216, 343},
        '{ 96, 103, 376, 423},
        '{136, 143,  96, 183},
        '{136, 143, 256, 303},
        '{136, 143, 416, 463},
        '{176, 183,  56, 103},
        '{176, 183, 136, 223},
        '{176, 183, 296, 423},
        '{216, 223,  16,  63},
        '{216, 223, 176, 223},
        '{216, 223, 256, 383},
        '{256, 263,  56, 143},
        '{256, 263, 176, 303},
        '{256, 263, 336, 423},
        '{296, 303, 136, 183},
        '{296, 303, 216, 303},
        '{296, 303, 336, 383},
        '{336, 343, 136, 183},
        '{336, 343, 256, 343},
        '{336, 343, 416, 463},
        '{376, 383,  16,  63},
        '{376, 383,  96, 183},
        '{376, 383, 216, 263},
        '{376, 383, 336, 383},
        '{416, 423,  16, 143},
        '{416, 423, 176, 263},
        '{456, 463,  16, 383},
        '{456, 463, 416, 463}
    };

endpackage

/* design/move_pkg.sv */
package move_pkg;

    typedef enum logic [2:0] {
        DIR_NONE,
        DIR_LEFT,
        DIR_RIGHT,
        DIR_UP,
        DIR_DOWN
    } dir_t;

    // Animate cycles between button samples
    localparam int STEP_PERIOD = 8;

    typedef logic [$clog2(STEP_PERIOD)-1:0] step_cnt_t;

endpackage

/* design/move_if.sv */
interface move_if
    import maze_pkg::*, move_pkg::*;
();

    // Request from decode
    logic   req_valid;
    dir_t   req_dir;
    coord_t probe_a;
    coord_t probe_b;
    coord_t probe_c;
    coord_t probe_y;

    // Verdict from wall check
    logic   vrd_valid;
    dir_t   vrd_dir;
    logic   vrd_blocked;

    modport decode (
        output req_valid, req_dir, probe_a, probe_b, probe_c, probe_y
    );

    modport check (
        input  req_valid, req_dir, probe_a, probe_b, probe_c, probe_y,
        output vrd_valid, vrd_dir, vrd_blocked
    );

    modport update (
        input vrd_valid, vrd_dir, vrd_blocked
    );

endinterface

/* design/move_decode.sv */
module move_decode
    import maze_pkg::*, move_pkg::*;
(
    input  logic   animate,
    input  logic   rst,
    input  logic   left,
    input  logic   right,
    input  logic   up,
    input  logic   down,
    input  coord_t cur_x,
    input  coord_t cur_y,
    move_if.decode req
);

    step_cnt_t cnt;
    logic      tick;
    dir_t      dir;
    coord_t    pa;
    coord_t    pb;
    coord_t    pc;
    coord_t    py;

    assign tick = (cnt == step_cnt_t'(STEP_PERIOD - 1));

    always_ff @(posedge animate)
    begin
        if (rst || tick)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // Opposite pair pressed together falls through to the next pair
    always_comb
    begin
        if (left && !right)
            dir = DIR_LEFT;
        else if (right && !left)
            dir = DIR_RIGHT;
        else if (up && !down)
            dir = DIR_UP;
        else if (down && !up)
            dir = DIR_DOWN;
        else
            dir = DIR_NONE;
    end

    //////////////////////////////
    // Probe points at the new position
    always_comb
    begin
        pa = cur_x;
        pb = cur_x;
        pc = cur_x;
        py = cur_y;
        case (dir)
            DIR_LEFT:
            begin
                pa = cur_x - STEP;
                pb = cur_x + MID_OFS - STEP;
                pc = cur_x + FAR_OFS - STEP;
            end
            DIR_RIGHT:
            begin
                pa = cur_x + STEP;
                pb = cur_x + MID_OFS + STEP;
                pc = cur_x + FAR_OFS + STEP;
            end
            // Up moves toward larger y
            DIR_UP:   py = cur_y + FAR_OFS + STEP;
            DIR_DOWN: py = cur_y - STEP;
            default:  ;
        endcase
    end

    always_ff @(posedge animate)
    begin
        if (rst)
            req.req_valid <= 1'b0;
        else
            req.req_valid <= tick && (dir != DIR_NONE);
    end

    always_ff @(posedge animate)
    begin
        if (tick)
        begin
            req.req_dir <= dir;
            req.probe_a <= pa;
            req.probe_b <= pb;
            req.probe_c <= pc;
            req.probe_y <= py;
        end
    end

endmodule

/* design/wall_check.sv */
module wall_check
    import maze_pkg::*, move_pkg::*;
(
    input  logic  animate,
    input  logic  rst,
    move_if.check chk
);

    logic blocked;

    // Inclusive in both axes
    function automatic logic hits_wall(input coord_t px, input coord_t py);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < WALL_COUNT; i++)
        begin
            if (px >= WALLS[i].x_lo && px <= WALLS[i].x_hi &&
                py >= WALLS[i].y_lo && py <= WALLS[i].y_hi)
            begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign blocked = hits_wall(chk.probe_a, chk.probe_y)
                   | hits_wall(chk.probe_b, chk.probe_y)
                   | hits_wall(chk.probe_c, chk.probe_y);

    always_ff @(posedge animate)
    begin
        if (rst)
            chk.vrd_valid <= 1'b0;
        else
            chk.vrd_valid <= chk.req_valid;
    end

    always_ff @(posedge animate)
    begin
        if (chk.req_valid)
        begin
            chk.vrd_dir     <= chk.req_dir;
            chk.vrd_blocked <= blocked;
        end
    end

endmodule

/* design/position_update.sv */
module position_update
    import maze_pkg::*, move_pkg::*;
(
    input  logic   animate,
    input  logic   rst,
    move_if.update upd,
    output coord_t cur_x,
    output coord_t cur_y,
    output coord_t x1,
    output coord_t x2,
    output coord_t y1,
    output coord_t y2
);

    coord_t near_x;
    coord_t near_y;

    // Steps wrap modulo 1024
    always_ff @(posedge animate)
    begin
        if (rst)
        begin
            near_x <= START_X;
            near_y <= START_Y;
        end
        else if (upd.vrd_valid && !upd.vrd_blocked)
        begin
            case (upd.vrd_dir)
                DIR_LEFT:  near_x <= near_x - STEP;
                DIR_RIGHT: near_x <= near_x + STEP;
                DIR_UP:    near_y <= near_y + STEP;
                DIR_DOWN:  near_y <= near_y - STEP;
                default:   ;
            endcase
        end
    end

    //////////////////////////////
    // Sprite edges
    assign x1 = near_x;
    assign y1 = near_y;
    assign x2 = near_x + FAR_OFS;
    assign y2 = near_y + FAR_OFS;

    assign cur_x = near_x;
    assign cur_y = near_y;

endmodule

/* design/maze_mover.sv */
module maze_mover
    import maze_pkg::*;
(
    input  logic   animate,
    input  logic   rst,
    input  logic   left,
    input  logic   right,
    input  logic   up,
    input  logic   down,
    output coord_t x1,
    output coord_t x2,
    output coord_t y1,
    output coord_t y2
);

    coord_t cur_x;
    coord_t cur_y;

    move_if u_move_if ();

    // Buttons to probe request
    move_decode u_move_decode (
        .animate (animate),
        .rst     (rst),
        .left    (left),
        .right   (right),
        .up      (up),
        .down    (down),
        .cur_x   (cur_x),
        .cur_y   (cur_y),
        .req     (u_move_if.decode)
    );

    wall_check u_wall_check (
        .animate (animate),
        .rst     (rst),
        .chk     (u_move_if.check)
    );

    position_update u_position_update (
        .animate (animate),
        .rst     (rst),
        .upd     (u_move_if.update),
        .cur_x   (cur_x),
        .cur_y   (cur_y),
        .x1      (x1),
        .x2      (x2),
        .y1      (y1),
        .y2      (y2)
    );

endmodule

/* include/tb_maze_model.svh */
`ifndef TB_MAZE_MODEL_SVH
`define TB_MAZE_MODEL_SVH

// Sprite geometry as seen by the probes
localparam coord_t M_STEP = 10'd10;
localparam coord_t M_MID  = 10'd7;
localparam coord_t M_FAR  = 10'd15;

// Point inside any wall rectangle, edges included
function automatic logic wall_at(input coord_t px, input coord_t py);
    for (int i = 0; i < WALL_COUNT; i++)
    begin
        if (px >= WALLS[i].x_lo && px <= WALLS[i].x_hi &&
            py >= WALLS[i].y_lo && py <= WALLS[i].y_hi)
            return 1'b1;
    end
    return 1'b0;
endfunction

// Buttons as {left, right, up, down}
function automatic dir_t pick_dir(input logic [3:0] btn);
    if (btn[3] && !btn[2])
        return DIR_LEFT;
    if (btn[2] && !btn[3])
        return DIR_RIGHT;
    if (btn[1] && !btn[0])
        return DIR_UP;
    if (btn[0] && !btn[1])
        return DIR_DOWN;
    return DIR_NONE;
endfunction

//////////////////////////////
// One step opportunity
function automatic void model_move(input logic [3:0] btn, inout coord_t x, inout coord_t y);
    dir_t dir;
    logic hit;
    dir = pick_dir(btn);
    hit = 1'b0;
    case (dir)
        DIR_LEFT:
        begin
            hit = wall_at(x - M_STEP, y) || wall_at(x + M_MID - M_STEP, y)
                || wall_at(x + M_FAR - M_STEP, y);
            if (!hit)
                x = x - M_STEP;
        end
        DIR_RIGHT:
        begin
            hit = wall_at(x + M_STEP, y) || wall_at(x + M_MID + M_STEP, y)
                || wall_at(x + M_FAR + M_STEP, y);
            if (!hit)
                x = x + M_STEP;
        end
        // Up grows y
        DIR_UP:
        begin
            if (!wall_at(x, y + M_FAR + M_STEP))
                y = y + M_STEP;
        end
        DIR_DOWN:
        begin
            if (!wall_at(x, y - M_STEP))
                y = y - M_STEP;
        end
        default:
        begin
        end
    endcase
endfunction

`endif

/* testbench/tb_maze_mover.sv */
module tb_maze_mover
    import maze_pkg::*, move_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        logic [3:0] btn;
        int         periods;
        coord_t     x;
        coord_t     y;
    } row_t;

    logic   animate = 1'b0;
    logic   rst;
    logic   left;
    logic   right;
    logic   up;
    logic   down;
    coord_t x1;
    coord_t x2;
    coord_t y1;
    coord_t y2;

    row_t   rows[$];
    coord_t exp_x;
    coord_t exp_y;
    logic   tbl_pending;
    coord_t tbl_x;
    coord_t tbl_y;

    `include "tb_maze_model.svh"

    always #4 animate = ~animate;

    maze_mover u_maze_mover (
        .animate (animate),
        .rst     (rst),
        .left    (left),
        .right   (right),
        .up      (up),
        .down    (down),
        .x1      (x1),
        .x2      (x2),
        .y1      (y1),
        .y2      (y2)
    );

    //////////////////////////////
    // Checks
    task automatic check_coord(input string name, input coord_t got, input coord_t want);
        if (got !== want)
        begin
            $display("mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, want);
            $display("=== FAIL ===");
            $fatal(1, "output value check failed");
        end
    endtask

    // Far edge sits 15 pixels past the near edge
    task automatic check_geometry(input string name, input coord_t near, input coord_t far);
        coord_t want;
        want = near + 10'd15;
        if (far !== want)
        begin
            $display("mismatch at %0d ns: %s got %0d expected %0d", $time, name, far, want);
            $display("=== FAIL ===");
            $fatal(1, "sprite geometry check failed");
        end
    endtask

    task automatic wait_edges(input int n);
        int      seen;
        realtime t0;
        seen = 0;
        while (seen < n)
        begin
            t0 = $realtime;
            fork
                @(posedge animate);
                #20;
            join_any
            if ($realtime - t0 >= 20.0)
            begin
                $display("timeout: no rising clock edge within 20 ns");
                $display("=== FAIL ===");
                $fatal(1, "wait timed out");
            end
            seen++;
        end
        #1;
    endtask

    // Previous step shows up two edges after the tick
    task automatic run_period(input logic [3:0] btn);
        {left, right, up, down} = btn;
        wait_edges(2);
        check_coord("x1", x1, exp_x);
        check_coord("y1", y1, exp_y);
        check_geometry("x2", x1, x2);
        check_geometry("y2", y1, y2);
        if (tbl_pending)
        begin
            check_coord("x1", x1, tbl_x);
            check_coord("y1", y1, tbl_y);
            tbl_pending = 1'b0;
        end
        wait_edges(STEP_PERIOD - 2);
        model_move(btn, exp_x, exp_y);
    endtask

    task automatic add_row(input logic [3:0] btn, input int periods,
                           input coord_t x, input coord_t y);
        row_t r;
        r.btn = btn;
        r.periods = periods;
        r.x = x;
        r.y = y;
        rows.push_back(r);
    endtask

    //////////////////////////////
    // Stimulus
    initial
    begin
        int   seed;
        int   rnd;
        row_t row;
        rst = 1'b1;
        {left, right, up, down} = 4'b0000;
        tbl_pending = 1'b0;
        tbl_x = '0;
        tbl_y = '0;
        seed = 60309;

        // Buttons {left, right, up, down}
        add_row(4'b0000, 1, 10'd16, 10'd72);
        add_row(4'b0001, 1, 10'd16, 10'd72);
        add_row(4'b0010, 1, 10'd16, 10'd72);
        add_row(4'b0100, 1, 10'd26, 10'd72);
        add_row(4'b0100, 3, 10'd56, 10'd72);
        add_row(4'b0100, 11, 10'd156, 10'd72);
        add_row(4'b1010, 5, 10'd106, 10'd72);
        add_row(4'b0010, 3, 10'd106, 10'd102);
        add_row(4'b1000, 1, 10'd106, 10'd102);
        add_row(4'b0001, 1, 10'd106, 10'd92);
        add_row(4'b1110, 1, 10'd106, 10'd102);
        add_row(4'b1111, 1, 10'd106, 10'd102);
        add_row(4'b1101, 2, 10'd106, 10'd82);

        wait_edges(10);
        rst = 1'b0;
        check_coord("x1", x1, 10'd16);
        check_coord("y1", y1, 10'd72);
        check_coord("x2", x2, 10'd31);
        check_coord("y2", y2, 10'd87);
        exp_x = 10'd16;
        exp_y = 10'd72;

        foreach (rows[i])
        begin
            row = rows[i];
            for (int p = 0; p < row.periods; p++)
                run_period(row.btn);
            tbl_pending = 1'b1;
            tbl_x = row.x;
            tbl_y = row.y;
        end

        for (int k = 0; k < 200; k++)
        begin
            rnd = $random(seed);
            run_period(rnd[3:0]);
        end
        // Idle period exposes the last step
        run_period(4'b0000);

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* src.f */
+incdir+include
design/maze_pkg.sv
design/move_pkg.sv
design/move_if.sv
design/move_decode.sv
design/wall_check.sv
design/position_update.sv
design/maze_mover.sv
testbench/tb_maze_mover.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_maze_mover
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
